// File: hdl/xform_params.svh
/*
  size and count macros for the transform core
  XFORM_POINTS must equal 2**XFORM_ADDR_W, and XFORM_STAGES must be XFORM_ADDR_W
  address counters wrap on their own and rely on this
*/
`ifndef XFORM_PARAMS_SVH
`define XFORM_PARAMS_SVH

// samples per frame
`define XFORM_POINTS 16

// bank address width
`define XFORM_ADDR_W 4

// radix-2 stages per frame
`define XFORM_STAGES 4

// sample width, two's complement
`define XFORM_DATA_W 16

`endif

// File: hdl/xform_ctrl_pkg.sv
/*
  control-side types of the transform core
  encodings are local to the core and carry no external meaning
*/
package xform_ctrl_pkg;

	// frame-level FSM states
	typedef enum logic [1:0]
	{
		IDLE    = 2'd0,
		SINK    = 2'd1,
		COMPUTE = 2'd2,
		SOURCE  = 2'd3
	} ctrl_state_t;

	// what the two banks serve in the current cycle
	typedef enum logic [1:0]
	{
		MODE_IDLE    = 2'd0,
		MODE_SINK    = 2'd1,
		MODE_COMPUTE = 2'd2,
		MODE_SOURCE  = 2'd3
	} bank_mode_t;

endpackage

// File: hdl/xform_data_pkg.sv
/*
  data-side types of the transform core
  sample arithmetic wraps at XFORM_DATA_W bits
*/
`include "xform_params.svh"

package xform_data_pkg;

	// one signed sample
	typedef logic signed [`XFORM_DATA_W-1:0] sample_t;

	// bank word address
	typedef logic [`XFORM_ADDR_W-1:0] addr_t;

	// stage index, holds 0 up to XFORM_STAGES
	typedef logic [$clog2(`XFORM_STAGES+1)-1:0] stage_t;

endpackage

// File: hdl/frame_bank.sv
/*
  one frame memory bank
  one write port, one read port, read data valid one cycle after rd_en
  a write and a read at the same address in one cycle return the old word
*/
`timescale 1ns/1ps
`include "xform_params.svh"

module frame_bank
	import xform_data_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    wr_en,
	input  addr_t   wr_addr,
	input  sample_t wr_data,
	input  logic    rd_en,
	input  addr_t   rd_addr,
	output sample_t rd_data
);

	// sample storage, no reset
	sample_t mem [`XFORM_POINTS];

	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			mem[wr_addr] <= wr_data;
		end
	end

	// registered read port
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_data <= '0;
		end
		else if (rd_en)
		begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

// File: hdl/stage_counter.sv
/*
  pair and stage counter for the compute phase
  stage_last and frame_last are registered, one cycle after the final pair_step
  stage returns to zero together with frame_last
*/
`timescale 1ns/1ps
`include "xform_params.svh"

module stage_counter
	import xform_data_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   stage_start,
	input  logic   pair_step,
	output addr_t  pair_index,
	output stage_t stage,
	output logic   stage_last,
	output logic   frame_last
);

	// half the frame per stage
	localparam addr_t  LAST_PAIR  = addr_t'(`XFORM_POINTS / 2 - 1);
	localparam stage_t LAST_STAGE = stage_t'(`XFORM_STAGES - 1);

	// ------------------------------
	// counters
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pair_index <= '0;
			stage      <= '0;
			stage_last <= 1'b0;
			frame_last <= 1'b0;
		end
		else
		begin
			// strobes default low
			stage_last <= 1'b0;
			frame_last <= 1'b0;
			if (stage_start)
			begin
				// resync at each stage entry
				pair_index <= '0;
			end
			else if (pair_step)
			begin
				if (pair_index == LAST_PAIR)
				begin
					pair_index <= '0;
					stage_last <= 1'b1;
					if (stage == LAST_STAGE)
					begin
						// frame done so stage returns to 0
						frame_last <= 1'b1;
						stage      <= '0;
					end
					else
					begin
						stage <= stage + stage_t'(1);
					end
				end
				else
				begin
					pair_index <= pair_index + addr_t'(1);
				end
			end
		end
	end

endmodule

// File: hdl/butterfly_engine.sv
/*
  radix-2 sum/difference engine, four cycles per pair
  phase 0 reads lower, 1 reads upper, 2 writes sum, 3 writes difference
  read and write go to different banks, so no hazard between them
  stops by itself after the final pair, restarts on stage_start
*/
`timescale 1ns/1ps
`include "xform_params.svh"

module butterfly_engine
	import xform_data_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    stage_start,
	input  stage_t  stage,
	input  addr_t   pair_index,
	output logic    rd_en,
	output addr_t   rd_addr,
	input  sample_t rd_data,
	output logic    wr_en,
	output addr_t   wr_addr,
	output sample_t wr_data,
	output logic    pair_step
);

	localparam addr_t LAST_PAIR = addr_t'(`XFORM_POINTS / 2 - 1);

	logic       active;
	logic [1:0] phase;
	addr_t      lo_addr;
	addr_t      hi_addr;
	sample_t    op_lo;
	sample_t    op_hi;

	// insert a zero bit at position s of k
	function automatic addr_t pair_lower(addr_t k, stage_t s);
		addr_t low_mask;
		low_mask = (addr_t'(1) << s) - addr_t'(1);
		return ((k & ~low_mask) << 1) | (k & low_mask);
	endfunction

	assign lo_addr = pair_lower(pair_index, stage);
	assign hi_addr = lo_addr | (addr_t'(1) << stage);

	// ------------------------------
	// phase sequencer
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			active <= 1'b0;
			phase  <= 2'd0;
		end
		else if (stage_start)
		begin
			active <= 1'b1;
			phase  <= 2'd0;
		end
		else if (active)
		begin
			phase <= phase + 2'd1;
			// counter raises stage_last off this same step
			if (phase == 2'd3 && pair_index == LAST_PAIR)
			begin
				active <= 1'b0;
			end
		end
	end

	// operands captured one cycle after each read
	always_ff @(posedge clk)
	begin
		if (active && phase == 2'd1)
		begin
			op_lo <= rd_data;
		end
		if (active && phase == 2'd2)
		begin
			op_hi <= rd_data;
		end
	end

	// lower address on even phases, upper on odd
	assign rd_en   = active && !phase[1];
	assign rd_addr = phase[0] ? hi_addr : lo_addr;
	assign wr_en   = active && phase[1];
	assign wr_addr = phase[0] ? hi_addr : lo_addr;

	// sum uses the upper operand straight off the bank
	assign wr_data = phase[0] ? sample_t'(op_lo - op_hi) : sample_t'(op_lo + rd_data);

	assign pair_step = active && phase == 2'd3;

endmodule

// File: hdl/bank_router.sv
/*
  sink and source address counters, steering of sink, engine and source onto the banks
  sink always fills bank_a; source reads the bank given by the stage count parity
  source_done is registered and also stops further source reads
*/
`timescale 1ns/1ps
`include "xform_params.svh"

module bank_router
	import xform_ctrl_pkg::*;
	import xform_data_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  bank_mode_t bank_mode,
	input  stage_t     stage,
	input  logic       sink_valid,
	input  sample_t    sink_data,
	input  logic       eng_rd_en,
	input  addr_t      eng_rd_addr,
	input  logic       eng_wr_en,
	input  addr_t      eng_wr_addr,
	input  sample_t    eng_wr_data,
	output sample_t    eng_rd_data,
	output logic       source_valid,
	output logic       source_sop,
	output sample_t    source_data,
	output logic       sink_done,
	output logic       source_done,
	output logic       bank_a_wr_en,
	output addr_t      bank_a_wr_addr,
	output sample_t    bank_a_wr_data,
	output logic       bank_a_rd_en,
	output addr_t      bank_a_rd_addr,
	input  sample_t    bank_a_rd_data,
	output logic       bank_b_wr_en,
	output addr_t      bank_b_wr_addr,
	output sample_t    bank_b_wr_data,
	output logic       bank_b_rd_en,
	output addr_t      bank_b_rd_addr,
	input  sample_t    bank_b_rd_data
);

	localparam addr_t LAST_ADDR = addr_t'(`XFORM_POINTS - 1);
	// final frame sits in bank_b for an odd stage count
	localparam bit    SRC_BANK  = (`XFORM_STAGES % 2) != 0;

	addr_t sink_addr;
	addr_t src_addr;
	logic  sink_wr;
	logic  src_rd;

	assign sink_wr   = (bank_mode == MODE_SINK) && sink_valid;
	assign src_rd    = (bank_mode == MODE_SOURCE) && !source_done;
	// combinational so a sample right after the frame is not taken
	assign sink_done = sink_wr && (sink_addr == LAST_ADDR);

	// ------------------------------
	// address counters
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			sink_addr    <= '0;
			src_addr     <= '0;
			source_valid <= 1'b0;
			source_sop   <= 1'b0;
			source_done  <= 1'b0;
		end
		else
		begin
			// both wrap to zero after a full frame
			if (sink_wr)
				sink_addr <= sink_addr + addr_t'(1);
			if (src_rd)
				src_addr <= src_addr + addr_t'(1);
			// one cycle behind the bank read
			source_valid <= src_rd;
			source_sop   <= src_rd && (src_addr == '0);
			source_done  <= src_rd && (src_addr == LAST_ADDR);
		end
	end

	// ------------------------------
	// port steering
	// ------------------------------
	always_comb
	begin
		bank_a_wr_en   = 1'b0;
		bank_a_wr_addr = eng_wr_addr;
		bank_a_wr_data = eng_wr_data;
		bank_a_rd_en   = 1'b0;
		bank_a_rd_addr = eng_rd_addr;
		bank_b_wr_en   = 1'b0;
		bank_b_wr_addr = eng_wr_addr;
		bank_b_wr_data = eng_wr_data;
		bank_b_rd_en   = 1'b0;
		bank_b_rd_addr = eng_rd_addr;
		case (bank_mode)
			MODE_SINK:
			begin
				bank_a_wr_en   = sink_valid;
				bank_a_wr_addr = sink_addr;
				bank_a_wr_data = sink_data;
			end
			MODE_COMPUTE:
			begin
				// odd stage reads bank_b, even stage reads bank_a
				if (stage[0])
				begin
					bank_b_rd_en = eng_rd_en;
					bank_a_wr_en = eng_wr_en;
				end
				else
				begin
					bank_a_rd_en = eng_rd_en;
					bank_b_wr_en = eng_wr_en;
				end
			end
			MODE_SOURCE:
			begin
				if (SRC_BANK)
				begin
					bank_b_rd_en   = src_rd;
					bank_b_rd_addr = src_addr;
				end
				else
				begin
					bank_a_rd_en   = src_rd;
					bank_a_rd_addr = src_addr;
				end
			end
			default:
			begin
			end
		endcase
	end

	// engine read data picked by stage parity, which holds through the read
	assign eng_rd_data = stage[0] ? bank_b_rd_data : bank_a_rd_data;
	assign source_data = SRC_BANK ? bank_b_rd_data : bank_a_rd_data;

endmodule

// File: hdl/xform_ctrl_fsm.sv
/*
  frame-level FSM stepping through idle, sink, compute stages and source
  a new frame starts only from IDLE; the sop sample is written in the accepting cycle
  bank_mode and busy are decoded from state, bank_mode also looks at the sop input
*/
`timescale 1ns/1ps

module xform_ctrl_fsm
	import xform_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       sink_valid,
	input  logic       sink_sop,
	input  logic       sink_done,
	input  logic       stage_last,
	input  logic       frame_last,
	input  logic       source_done,
	output bank_mode_t bank_mode,
	output logic       stage_start,
	output logic       busy
);

	ctrl_state_t state;
	logic        sop_accept;

	assign sop_accept = sink_valid && sink_sop;

	// ------------------------------
	// state register
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state       <= IDLE;
			stage_start <= 1'b0;
		end
		else
		begin
			stage_start <= 1'b0;
			case (state)
				IDLE:
				begin
					if (sop_accept)
						state <= SINK;
				end
				SINK:
				begin
					// first stage kicks off on entry
					if (sink_done)
					begin
						state       <= COMPUTE;
						stage_start <= 1'b1;
					end
				end
				COMPUTE:
				begin
					if (stage_last)
					begin
						if (frame_last)
							state <= SOURCE;
						else
							stage_start <= 1'b1;
					end
				end
				SOURCE:
				begin
					if (source_done)
						state <= IDLE;
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	// ------------------------------
	// bank mode decode
	// ------------------------------
	always_comb
	begin
		case (state)
			// sop cycle already writes bank_a
			IDLE:    bank_mode = sop_accept ? MODE_SINK : MODE_IDLE;
			SINK:    bank_mode = MODE_SINK;
			COMPUTE: bank_mode = MODE_COMPUTE;
			SOURCE:  bank_mode = MODE_SOURCE;
			default: bank_mode = MODE_IDLE;
		endcase
	end

	// high from the cycle after sop to the cycle after the last sample
	assign busy = (state != IDLE);

endmodule

// File: hdl/xform_top.sv
/*
  top level of the Walsh-Hadamard transform core
  frames of XFORM_POINTS samples, one accepted at a time, no back-pressure on source
  sink_valid and sink_sop outside a frame are ignored while busy
*/
`timescale 1ns/1ps

module xform_top
	import xform_ctrl_pkg::*;
	import xform_data_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    sink_valid,
	input  logic    sink_sop,
	input  sample_t sink_data,
	output logic    source_valid,
	output logic    source_sop,
	output sample_t source_data,
	output logic    busy
);

	// control strobes
	bank_mode_t bank_mode;
	logic       stage_start;
	logic       sink_done;
	logic       source_done;
	logic       stage_last;
	logic       frame_last;
	logic       pair_step;
	addr_t      pair_index;
	stage_t     stage;

	// engine side
	logic    eng_rd_en;
	addr_t   eng_rd_addr;
	sample_t eng_rd_data;
	logic    eng_wr_en;
	addr_t   eng_wr_addr;
	sample_t eng_wr_data;

	// bank ports
	logic    a_wr_en, b_wr_en;
	addr_t   a_wr_addr, b_wr_addr;
	sample_t a_wr_data, b_wr_data;
	logic    a_rd_en, b_rd_en;
	addr_t   a_rd_addr, b_rd_addr;
	sample_t a_rd_data, b_rd_data;

	// ------------------------------
	// control
	// ------------------------------
	xform_ctrl_fsm u_fsm (
		.clk(clk), .rst_n(rst_n), .sink_valid(sink_valid), .sink_sop(sink_sop),
		.sink_done(sink_done), .stage_last(stage_last), .frame_last(frame_last),
		.source_done(source_done), .bank_mode(bank_mode), .stage_start(stage_start),
		.busy(busy)
	);

	stage_counter u_counter (
		.clk(clk), .rst_n(rst_n), .stage_start(stage_start), .pair_step(pair_step),
		.pair_index(pair_index), .stage(stage), .stage_last(stage_last),
		.frame_last(frame_last)
	);

	// ------------------------------
	// datapath
	// ------------------------------
	butterfly_engine u_engine (
		.clk(clk), .rst_n(rst_n), .stage_start(stage_start), .stage(stage),
		.pair_index(pair_index), .rd_en(eng_rd_en), .rd_addr(eng_rd_addr),
		.rd_data(eng_rd_data), .wr_en(eng_wr_en), .wr_addr(eng_wr_addr),
		.wr_data(eng_wr_data), .pair_step(pair_step)
	);

	bank_router u_router (
		.clk(clk), .rst_n(rst_n), .bank_mode(bank_mode), .stage(stage),
		.sink_valid(sink_valid), .sink_data(sink_data),
		.eng_rd_en(eng_rd_en), .eng_rd_addr(eng_rd_addr), .eng_wr_en(eng_wr_en),
		.eng_wr_addr(eng_wr_addr), .eng_wr_data(eng_wr_data), .eng_rd_data(eng_rd_data),
		.source_valid(source_valid), .source_sop(source_sop), .source_data(source_data),
		.sink_done(sink_done), .source_done(source_done),
		.bank_a_wr_en(a_wr_en), .bank_a_wr_addr(a_wr_addr), .bank_a_wr_data(a_wr_data),
		.bank_a_rd_en(a_rd_en), .bank_a_rd_addr(a_rd_addr), .bank_a_rd_data(a_rd_data),
		.bank_b_wr_en(b_wr_en), .bank_b_wr_addr(b_wr_addr), .bank_b_wr_data(b_wr_data),
		.bank_b_rd_en(b_rd_en), .bank_b_rd_addr(b_rd_addr), .bank_b_rd_data(b_rd_data)
	);

	// ping-pong pair
	frame_bank bank_a (
		.clk(clk), .rst_n(rst_n), .wr_en(a_wr_en), .wr_addr(a_wr_addr),
		.wr_data(a_wr_data), .rd_en(a_rd_en), .rd_addr(a_rd_addr), .rd_data(a_rd_data)
	);

	frame_bank bank_b (
		.clk(clk), .rst_n(rst_n), .wr_en(b_wr_en), .wr_addr(b_wr_addr),
		.wr_data(b_wr_data), .rd_en(b_rd_en), .rd_addr(b_rd_addr), .rd_data(b_rd_data)
	);

endmodule

// File: verif/xform_tb.sv
/*
  testbench for the Walsh-Hadamard transform core
  random frames from a fixed seed, compared against a model of the butterfly rule
  inputs driven on the rising edge, outputs observed on the falling edge
  a timeout in any wait ends the run
*/
`timescale 1ns/1ps
`include "xform_params.svh"

module xform_tb
	import xform_data_pkg::*;
();

	localparam int N       = `XFORM_POINTS;
	localparam int TIMEOUT = 2000;

	logic    clk;
	logic    rst_n;
	logic    sink_valid;
	logic    sink_sop;
	sample_t sink_data;
	logic    source_valid;
	logic    source_sop;
	sample_t source_data;
	logic    busy;

	integer  seed;
	int      checks;
	int      errors;
	int      timeouts;
	sample_t frame [N];
	sample_t ref_out [N];

	xform_top xform_top_inst (
		.clk(clk), .rst_n(rst_n), .sink_valid(sink_valid), .sink_sop(sink_sop),
		.sink_data(sink_data), .source_valid(source_valid), .source_sop(source_sop),
		.source_data(source_data), .busy(busy)
	);

	// 4 ns period
	always #2 clk = ~clk;

	// ------------------------------
	// checks
	// ------------------------------
	task automatic check_bit(string name, logic exp, logic act);
		checks++;
		assert (exp === act)
		else
		begin
			errors++;
			$display("error: %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_sample(string name, sample_t exp, sample_t act);
		checks++;
		assert (exp === act)
		else
		begin
			errors++;
			$display("error: %s expected %h actual %h", name, exp, act);
		end
	endtask

	// reference model with sum and difference over every address pair stage by stage
	task automatic build_reference();
		sample_t a;
		sample_t b;
		int      hi;
		for (int i = 0; i < N; i++)
			ref_out[i] = frame[i];
		for (int s = 0; s < `XFORM_STAGES; s++)
		begin
			for (int lo = 0; lo < N; lo++)
			begin
				// lower partner has bit s clear
				if (((lo >> s) & 1) == 0)
				begin
					hi          = lo + (1 << s);
					a           = ref_out[lo];
					b           = ref_out[hi];
					ref_out[lo] = a + b;
					ref_out[hi] = a - b;
				end
			end
		end
	endtask

	// stray strobes only ever driven outside SINK
	task automatic drive_inputs(bit junk);
		if (junk)
		begin
			sink_valid <= 1'($random(seed));
			sink_sop   <= 1'($random(seed));
			sink_data  <= sample_t'($random(seed));
		end
		else
		begin
			sink_valid <= 1'b0;
			sink_sop   <= 1'b0;
		end
	endtask

	task automatic check_idle(string name, int cycles);
		repeat (cycles)
		begin
			@(posedge clk);
			drive_inputs(1'b0);
			@(negedge clk);
			check_bit({name, " busy"}, 1'b0, busy);
			check_bit({name, " source_valid"}, 1'b0, source_valid);
			check_bit({name, " source_sop"}, 1'b0, source_sop);
		end
	endtask

	// sop on the first sample and optional idle cycles between samples
	task automatic send_frame(string name, bit gaps);
		int sent;
		int cyc;
		sent = 0;
		cyc  = 0;
		while (sent < N)
		begin
			@(posedge clk);
			if (gaps && sent > 0 && ($random(seed) & 3) == 0)
			begin
				sink_valid <= 1'b0;
				sink_sop   <= 1'b0;
			end
			else
			begin
				sink_valid <= 1'b1;
				sink_sop   <= (sent == 0);
				sink_data  <= frame[sent];
				sent++;
			end
			@(negedge clk);
			// busy rises one cycle after the sop is taken
			check_bit({name, " busy during sink"}, (cyc > 0), busy);
			cyc++;
		end
	endtask

	// ------------------------------
	// one frame in and one frame out
	// ------------------------------
	task automatic run_frame(string name, bit gaps, bit junk);
		int cycles;
		build_reference();
		send_frame(name, gaps);
		cycles = 0;
		while (!source_valid && cycles < TIMEOUT)
		begin
			@(posedge clk);
			drive_inputs(junk);
			@(negedge clk);
			cycles++;
		end
		if (!source_valid)
		begin
			$display("timeout: no output frame appeared in %s", name);
			timeouts++;
			return;
		end
		// sample 0 is already on the outputs
		for (int i = 0; i < N; i++)
		begin
			if (i > 0)
			begin
				@(posedge clk);
				drive_inputs(junk && i < N / 2);
				@(negedge clk);
			end
			check_bit($sformatf("%s valid %0d", name, i), 1'b1, source_valid);
			check_bit($sformatf("%s sop %0d", name, i), (i == 0), source_sop);
			check_bit($sformatf("%s busy %0d", name, i), 1'b1, busy);
			check_sample($sformatf("%s sample %0d", name, i), ref_out[i], source_data);
		end
		// busy falls and no extra sample follows the last one
		@(posedge clk);
		drive_inputs(1'b0);
		@(negedge clk);
		check_bit({name, " valid after frame"}, 1'b0, source_valid);
		check_bit({name, " busy after frame"}, 1'b0, busy);
	endtask

	task automatic fill_random();
		for (int i = 0; i < N; i++)
			frame[i] = sample_t'($random(seed));
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial
	begin
		seed       = 32'hc25f1078;
		checks     = 0;
		errors     = 0;
		timeouts   = 0;
		clk        = 1'b0;
		rst_n      = 1'b0;
		sink_valid = 1'b0;
		sink_sop   = 1'b0;
		sink_data  = '0;

		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		check_idle("reset", 20);

		for (int f = 0; f < 20 && timeouts == 0; f++)
		begin
			fill_random();
			run_frame($sformatf("random frame %0d", f), 1'b0, 1'b0);
		end

		for (int f = 0; f < 8 && timeouts == 0; f++)
		begin
			fill_random();
			run_frame($sformatf("gapped frame %0d", f), 1'b1, 1'b0);
		end

		// strobes while busy must leave this frame and the next one intact
		for (int f = 0; f < 4 && timeouts == 0; f++)
		begin
			fill_random();
			run_frame($sformatf("ignored input frame %0d", f), 1'b0, 1'b1);
		end

		// corner values where sums wrap past the sample range
		if (timeouts == 0)
		begin
			for (int i = 0; i < N; i++)
				frame[i] = sample_t'(16'h7fff);
			run_frame("all max frame", 1'b0, 1'b0);
		end
		if (timeouts == 0)
		begin
			for (int i = 0; i < N; i++)
				frame[i] = (i % 2 == 0) ? sample_t'(16'h7fff) : sample_t'(16'h8000);
			run_frame("alternating sign frame", 1'b0, 1'b0);
		end
		if (timeouts == 0)
		begin
			for (int i = 0; i < N; i++)
				frame[i] = sample_t'(16'h8000);
			run_frame("all min frame", 1'b0, 1'b0);
		end

		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: sources.f
+incdir+hdl
hdl/xform_ctrl_pkg.sv
hdl/xform_data_pkg.sv
hdl/frame_bank.sv
hdl/stage_counter.sv
hdl/butterfly_engine.sv
hdl/bank_router.sv
hdl/xform_ctrl_fsm.sv
hdl/xform_top.sv
verif/xform_tb.sv

// File: Makefile
# Verilator build and run of the transform core testbench
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= xform_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --assert -j $(JOBS)

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard hdl/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)

check: run
	@test -s $(LOG) || { echo "no simulation log"; exit 1; }
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG) || { echo "simulation did not finish"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
